// ==== src/afu_pkg.sv ====
// ==================================================
// AFU shared definitions
// CSR geometry, word types and the test identifier
// used by the CSR manager and the memory engines
// ==================================================

package afu_pkg;

    // ==================================================
    // CSR geometry
    // ==================================================

    // Each CSR group holds four 64-bit registers
    localparam int CSR_IDX_BITS = 2;
    localparam int NUM_CSRS = 1 << CSR_IDX_BITS;

    // One CSR data word, also the width of a local memory word
    typedef logic [63:0] csr_data_t;

    // Register index within one group
    typedef logic [CSR_IDX_BITS-1:0] csr_idx_t;

    // ==================================================
    // Local memory
    // ==================================================

    // Word address into one local memory bank
    localparam int MEM_ADDR_BITS = 16;

    typedef logic [MEM_ADDR_BITS-1:0] mem_addr_t;

    // ==================================================
    // Identification
    // ==================================================

    // Software matches this value before it trusts the rest of the CSR map
    localparam logic [127:0] TEST_ID = 128'h5d1e_93a0_c4b7_4f28_a61d_0e7b_3c95_f214;

endpackage

// ==== src/engine_csr_if.sv ====
// ==================================================
// CSR group link
// Carries register writes from the CSR manager into
// one register group and its read data back
// ==================================================

interface engine_csr_if;

    import afu_pkg::*;

    // Single-cycle write strobe with its register index and data
    logic      wr_en;
    csr_idx_t  wr_idx;
    csr_data_t wr_data;

    // All registers of the group, presented in parallel for the read mux
    csr_data_t rd_data [NUM_CSRS];

    // High while the group's engine is running a test
    logic      status_active;

    // The manager side decodes the MMIO bus
    modport manager
    (
        output wr_en,
        output wr_idx,
        output wr_data,
        input  rd_data,
        input  status_active
    );

    // The group side owns the registers
    modport group
    (
        input  wr_en,
        input  wr_idx,
        input  wr_data,
        output rd_data,
        output status_active
    );

endinterface

// ==== src/csr_mgr.sv ====
// ==================================================
// CSR manager
// Splits MMIO accesses into global and engine groups,
// steers write strobes and registers read responses
// ==================================================

module csr_mgr
#(
    parameter int NUM_ENGINES = 2,
    parameter int MMIO_ADDR_WIDTH = 8
)
(
    input  logic                       clk,
    input  logic                       arst_n,

    // MMIO write channel
    input  logic                       wr_write,
    input  logic [MMIO_ADDR_WIDTH-1:0] wr_address,
    input  afu_pkg::csr_data_t         wr_writedata,

    // MMIO read channel
    input  logic                       rd_read,
    input  logic [MMIO_ADDR_WIDTH-1:0] rd_address,
    output logic                       rd_readdatavalid,
    output afu_pkg::csr_data_t         rd_readdata,

    // Register groups
    engine_csr_if.manager              eng_csr_glob,
    engine_csr_if.manager              eng_csr [NUM_ENGINES]
);

    import afu_pkg::*;

    // The address bits above the register index pick the group
    localparam int GRP_BITS = MMIO_ADDR_WIDTH - CSR_IDX_BITS;

    logic [GRP_BITS-1:0] wr_grp;
    logic [GRP_BITS-1:0] rd_grp;
    csr_idx_t            wr_idx;
    csr_idx_t            rd_idx;

    // Per-engine register selected by the read index
    csr_data_t           eng_rd [NUM_ENGINES];
    csr_data_t           rd_sel;

    assign {wr_grp, wr_idx} = wr_address;
    assign {rd_grp, rd_idx} = rd_address;

    // ==================================================
    // Write steering
    // ==================================================

    // Group 0 is the global group
    // Writes into a group whose engine is running are dropped so the
    // run keeps the base, count and seed it started with
    assign eng_csr_glob.wr_en   = wr_write && (wr_grp == '0) && !eng_csr_glob.status_active;
    assign eng_csr_glob.wr_idx  = wr_idx;
    assign eng_csr_glob.wr_data = wr_writedata;

    // Group g+1 belongs to engine g
    for (genvar g = 0; g < NUM_ENGINES; g++)
    begin : g_eng
        assign eng_csr[g].wr_en   = wr_write
                                    && (wr_grp == GRP_BITS'(g + 1))
                                    && !eng_csr[g].status_active;
        assign eng_csr[g].wr_idx  = wr_idx;
        assign eng_csr[g].wr_data = wr_writedata;

        // Each engine's register at the read index feeds the group mux below
        assign eng_rd[g] = eng_csr[g].rd_data[rd_idx];
    end

    // ==================================================
    // Read path
    // ==================================================

    // Unmapped groups fall through to zero
    always_comb
    begin
        rd_sel = '0;

        if (rd_grp == '0)
        begin
            rd_sel = eng_csr_glob.rd_data[rd_idx];
        end

        for (int g = 0; g < NUM_ENGINES; g++)
        begin
            if (rd_grp == GRP_BITS'(g + 1))
            begin
                rd_sel = eng_rd[g];
            end
        end
    end

    // Response valid follows the read by exactly one cycle
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rd_readdatavalid <= 1'b0;
        end
        else
        begin
            rd_readdatavalid <= rd_read;
        end
    end

    // Capture the addressed register for the response
    always_ff @(posedge clk)
    begin
        if (rd_read)
        begin
            rd_readdata <= rd_sel;
        end
    end

endmodule

// ==== src/local_mem_engine.sv ====
// ==================================================
// Local memory test engine
// Writes a seeded pattern into one bank, reads it
// back and reports checksum, mismatches and done
// ==================================================

module local_mem_engine
#(
    parameter int ENGINE_NUMBER = 0
)
(
    input  logic                clk,
    input  logic                arst_n,

    // Avalon-style memory port
    output afu_pkg::mem_addr_t  mem_address,
    output logic                mem_write,
    output logic                mem_read,
    output afu_pkg::csr_data_t  mem_writedata,
    input  logic                mem_waitrequest,
    input  afu_pkg::csr_data_t  mem_readdata,
    input  logic                mem_readdatavalid,

    // Register group
    engine_csr_if.group         csrs
);

    import afu_pkg::*;

    // Reads in flight are capped by the size of the outstanding counter
    localparam int MAX_OUTSTANDING = 8;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_WRITE,
        ST_READ,
        ST_DRAIN
    } state_t;

    state_t      state;

    // Run configuration written over the CSR bus
    mem_addr_t   base_q;
    mem_addr_t   count_q;
    logic [31:0] seed_q;

    // Request and response tracking
    mem_addr_t   issue_idx;
    mem_addr_t   ret_idx;
    mem_addr_t   last_idx;
    logic [3:0]  rd_outstanding;
    logic        req_accept;
    logic        start;

    // Results
    logic        done;
    csr_data_t   checksum;
    mem_addr_t   mismatch_cnt;
    mem_addr_t   exp_addr;
    csr_data_t   exp_data;

    // ==================================================
    // Configuration registers
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (csrs.wr_en)
        begin
            case (csrs.wr_idx)
                2'd0:
                begin
                    base_q <= csrs.wr_data[MEM_ADDR_BITS-1:0];
                end
                2'd1:
                begin
                    count_q <= csrs.wr_data[MEM_ADDR_BITS-1:0];
                    seed_q  <= csrs.wr_data[63:32];
                end
                default:
                begin
                end
            endcase
        end
    end

    // Any write to index 2 is a start, whatever its data
    assign start = csrs.wr_en && (csrs.wr_idx == 2'd2);

    // ==================================================
    // Request issue
    // ==================================================

    // Address and data come straight from registers that only move on
    // acceptance, so they stay put while the memory stalls
    assign mem_address   = base_q + issue_idx;
    assign mem_writedata = {seed_q, 16'h0000, mem_address};
    assign mem_write     = (state == ST_WRITE);
    assign mem_read      = (state == ST_READ) && (rd_outstanding != 4'(MAX_OUTSTANDING));
    assign req_accept    = (mem_write || mem_read) && !mem_waitrequest;
    assign last_idx      = count_q - 16'd1;

    // Pattern value for the word coming back next, responses are in order
    assign exp_addr = base_q + ret_idx;
    assign exp_data = {seed_q, 16'h0000, exp_addr};

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state          <= ST_IDLE;
            issue_idx      <= '0;
            ret_idx        <= '0;
            rd_outstanding <= '0;
            done           <= 1'b0;
            checksum       <= '0;
            mismatch_cnt   <= '0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    // A start only lands here, so one during a run is dropped
                    if (start)
                    begin
                        done         <= (count_q == '0);
                        checksum     <= '0;
                        mismatch_cnt <= '0;
                        issue_idx    <= '0;
                        ret_idx      <= '0;
                        if (count_q != '0)
                        begin
                            state <= ST_WRITE;
                        end
                    end
                end
                ST_WRITE:
                begin
                    // Every write is accepted before the first read goes out
                    if (req_accept)
                    begin
                        issue_idx <= (issue_idx == last_idx) ? '0 : issue_idx + 16'd1;
                        if (issue_idx == last_idx)
                        begin
                            state <= ST_READ;
                        end
                    end
                end
                ST_READ:
                begin
                    if (req_accept)
                    begin
                        issue_idx <= issue_idx + 16'd1;
                        if (issue_idx == last_idx)
                        begin
                            state <= ST_DRAIN;
                        end
                    end
                end
                default:
                begin
                    // Waiting for the tail of the read responses
                end
            endcase

            // ==================================================
            // Read-back compare
            // ==================================================

            if (mem_readdatavalid)
            begin
                checksum <= checksum + mem_readdata;
                ret_idx  <= ret_idx + 16'd1;
                if (mem_readdata != exp_data)
                begin
                    mismatch_cnt <= mismatch_cnt + 16'd1;
                end
                // The last response can only arrive after the last issue
                if (ret_idx == last_idx)
                begin
                    done  <= 1'b1;
                    state <= ST_IDLE;
                end
            end

            rd_outstanding <= rd_outstanding
                              + 4'(mem_read && req_accept)
                              - 4'(mem_readdatavalid);
        end
    end

    // ==================================================
    // Status readout
    // ==================================================

    assign csrs.status_active = (state != ST_IDLE);

    always_comb
    begin
        csrs.rd_data[0] = {62'd0, done, csrs.status_active};
        csrs.rd_data[1] = checksum;
        csrs.rd_data[2] = csr_data_t'(mismatch_cnt);
        csrs.rd_data[3] = csr_data_t'(ENGINE_NUMBER);
    end

endmodule

// ==== src/afu_top.sv ====
// ==================================================
// AFU top level
// Global CSRs, one memory test engine per bank and
// the CSR manager behind a plain MMIO port
// ==================================================

module afu_top
#(
    parameter int NUM_ENGINES = 2,
    parameter int MMIO_ADDR_WIDTH = 8
)
(
    input  logic                       clk,
    input  logic                       arst_n,

    // MMIO port, addressed in 64-bit words
    input  logic                       mmio_write,
    input  logic                       mmio_read,
    input  logic [MMIO_ADDR_WIDTH-1:0] mmio_address,
    input  afu_pkg::csr_data_t         mmio_writedata,
    output logic                       mmio_readdatavalid,
    output afu_pkg::csr_data_t         mmio_readdata,

    // One Avalon-style port per local memory bank
    output afu_pkg::mem_addr_t         mem_address [NUM_ENGINES],
    output logic [NUM_ENGINES-1:0]     mem_write,
    output logic [NUM_ENGINES-1:0]     mem_read,
    output afu_pkg::csr_data_t         mem_writedata [NUM_ENGINES],
    input  logic [NUM_ENGINES-1:0]     mem_waitrequest,
    input  afu_pkg::csr_data_t         mem_readdata [NUM_ENGINES],
    input  logic [NUM_ENGINES-1:0]     mem_readdatavalid
);

    import afu_pkg::*;

    engine_csr_if eng_csr_glob();
    engine_csr_if eng_csr [NUM_ENGINES]();

    // ==================================================
    // Global group
    // ==================================================

    // Read-only description of the AFU for software
    always_comb
    begin
        eng_csr_glob.rd_data[0] = TEST_ID[63:0];
        eng_csr_glob.rd_data[1] = TEST_ID[127:64];
        eng_csr_glob.rd_data[2] = csr_data_t'(NUM_ENGINES);
        eng_csr_glob.rd_data[3] = '0;
        // There is no engine behind the global group
        eng_csr_glob.status_active = 1'b0;
    end

    // ==================================================
    // Engines, one per bank
    // ==================================================

    for (genvar b = 0; b < NUM_ENGINES; b++)
    begin : g_bank
        local_mem_engine #(.ENGINE_NUMBER(b)) i_engine
        (
            .clk               (clk),
            .arst_n            (arst_n),
            .mem_address       (mem_address[b]),
            .mem_write         (mem_write[b]),
            .mem_read          (mem_read[b]),
            .mem_writedata     (mem_writedata[b]),
            .mem_waitrequest   (mem_waitrequest[b]),
            .mem_readdata      (mem_readdata[b]),
            .mem_readdatavalid (mem_readdatavalid[b]),
            .csrs              (eng_csr[b])
        );
    end

    // Reads and writes share one address bus
    csr_mgr #(.NUM_ENGINES(NUM_ENGINES), .MMIO_ADDR_WIDTH(MMIO_ADDR_WIDTH)) i_csr_mgr
    (
        .clk              (clk),
        .arst_n           (arst_n),
        .wr_write         (mmio_write),
        .wr_address       (mmio_address),
        .wr_writedata     (mmio_writedata),
        .rd_read          (mmio_read),
        .rd_address       (mmio_address),
        .rd_readdatavalid (mmio_readdatavalid),
        .rd_readdata      (mmio_readdata),
        .eng_csr_glob     (eng_csr_glob),
        .eng_csr          (eng_csr)
    );

endmodule

// ==== tb/afu_assertions.sv ====
// ==================================================
// Memory port protocol assertions
// Bound into every memory test engine
// ==================================================

module afu_assertions
(
    input logic               clk,
    input logic               arst_n,
    input afu_pkg::mem_addr_t mem_address,
    input logic               mem_write,
    input logic               mem_read,
    input afu_pkg::csr_data_t mem_writedata,
    input logic               mem_waitrequest,
    input logic               mem_readdatavalid,
    input logic [3:0]         rd_outstanding
);

    timeunit 1ns;
    timeprecision 100ps;

    // One request type per cycle on the shared address bus
    a_no_write_and_read: assert property (@(posedge clk) disable iff (!arst_n)
        !(mem_write && mem_read))
        else $error("memory write and read strobes high in the same cycle");

    // A stalled request keeps its strobe, address and write data
    a_hold_under_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (mem_write || mem_read) && mem_waitrequest
        |=> $stable(mem_write) && $stable(mem_read) && $stable(mem_address)
            && (!mem_write || $stable(mem_writedata)))
        else $error("memory request changed while waitrequest was high");

    // Every response must belong to a read that is still in flight
    a_response_has_read: assert property (@(posedge clk) disable iff (!arst_n)
        mem_readdatavalid |-> (rd_outstanding != 4'd0))
        else $error("read response arrived with no read outstanding");

endmodule

// ==== tb/tb_afu.sv ====
// ==================================================
// AFU testbench
// Vector-driven CSR sequences against a stalling
// local memory model, one bank per engine
// ==================================================

module tb_afu;

    timeunit 1ns;
    timeprecision 100ps;

    import afu_pkg::*;

    localparam int NUM_ENGINES = 2;
    localparam int MMIO_ADDR_WIDTH = 8;
    localparam int NUM_RUNS = 6;
    localparam int VEC_FIELDS = 7;
    localparam int POLL_LIMIT = 1000;

    // ==================================================
    // DUT signals and memory model state
    // ==================================================

    logic                       clk = 1'b0;
    logic                       arst_n;
    logic                       mmio_write;
    logic                       mmio_read;
    logic [MMIO_ADDR_WIDTH-1:0] mmio_address;
    csr_data_t                  mmio_writedata;
    logic                       mmio_readdatavalid;
    csr_data_t                  mmio_readdata;
    mem_addr_t                  mem_address [NUM_ENGINES];
    logic [NUM_ENGINES-1:0]     mem_write;
    logic [NUM_ENGINES-1:0]     mem_read;
    csr_data_t                  mem_writedata [NUM_ENGINES];
    logic [NUM_ENGINES-1:0]     mem_waitrequest = '0;
    csr_data_t                  mem_readdata [NUM_ENGINES] = '{default: '0};
    logic [NUM_ENGINES-1:0]     mem_readdatavalid = '0;

    // One 64K-word bank per engine and a single-word corruption hook
    csr_data_t                  bank_mem [NUM_ENGINES][65536];
    logic [NUM_ENGINES-1:0]     corrupt_en = '0;
    mem_addr_t                  corrupt_addr [NUM_ENGINES] = '{default: '0};
    logic                       stall_en = 1'b0;
    logic [15:0]                lfsr = 16'd47;
    logic [NUM_ENGINES-1:0]     ret_valid = '0;
    csr_data_t                  ret_data [NUM_ENGINES] = '{default: '0};

    // Seven hex fields per run as listed in the column line of the file
    csr_data_t                  vec [NUM_RUNS * VEC_FIELDS];

    always #4 clk = ~clk;

    afu_top #(.NUM_ENGINES(NUM_ENGINES), .MMIO_ADDR_WIDTH(MMIO_ADDR_WIDTH)) i_dut
    (
        .clk                (clk),
        .arst_n             (arst_n),
        .mmio_write         (mmio_write),
        .mmio_read          (mmio_read),
        .mmio_address       (mmio_address),
        .mmio_writedata     (mmio_writedata),
        .mmio_readdatavalid (mmio_readdatavalid),
        .mmio_readdata      (mmio_readdata),
        .mem_address        (mem_address),
        .mem_write          (mem_write),
        .mem_read           (mem_read),
        .mem_writedata      (mem_writedata),
        .mem_waitrequest    (mem_waitrequest),
        .mem_readdata       (mem_readdata),
        .mem_readdatavalid  (mem_readdatavalid)
    );

    bind local_mem_engine afu_assertions i_assertions
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .mem_address       (mem_address),
        .mem_write         (mem_write),
        .mem_read          (mem_read),
        .mem_writedata     (mem_writedata),
        .mem_waitrequest   (mem_waitrequest),
        .mem_readdatavalid (mem_readdatavalid),
        .rd_outstanding    (rd_outstanding)
    );

    // Galois LFSR with taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic [15:0] next;
        next = state >> 1;
        if (state[0])
        begin
            next = next ^ 16'hB400;
        end
        return next;
    endfunction

    // ==================================================
    // Memory model
    // ==================================================

    // Requests are sampled at the edge and responses and stalls move 1 ns later
    // Read data comes back in order two cycles after acceptance
    always @(posedge clk)
    begin : mem_model
        logic [NUM_ENGINES-1:0] accept_rd;
        logic [NUM_ENGINES-1:0] next_wait;
        csr_data_t              fetched [NUM_ENGINES];
        logic                   bit_a;
        logic                   bit_b;
        for (int b = 0; b < NUM_ENGINES; b++)
        begin
            accept_rd[b] = arst_n && mem_read[b] && !mem_waitrequest[b];
            fetched[b] = bank_mem[b][mem_address[b]];
            if (arst_n && mem_write[b] && !mem_waitrequest[b])
            begin
                bank_mem[b][mem_address[b]] = mem_writedata[b];
                if (corrupt_en[b] && (mem_address[b] == corrupt_addr[b]))
                begin
                    bank_mem[b][mem_address[b]] = mem_writedata[b] ^ 64'd1;
                end
            end
            next_wait[b] = 1'b0;
            if (stall_en)
            begin
                // Two bits per bank give a stall in about one cycle of four
                bit_a = lfsr[0];
                lfsr = lfsr_step(lfsr);
                bit_b = lfsr[0];
                lfsr = lfsr_step(lfsr);
                next_wait[b] = bit_a && bit_b;
            end
        end
        #1;
        for (int b = 0; b < NUM_ENGINES; b++)
        begin
            mem_readdatavalid[b] = ret_valid[b];
            mem_readdata[b] = ret_data[b];
            ret_valid[b] = accept_rd[b];
            ret_data[b] = fetched[b];
            mem_waitrequest[b] = next_wait[b];
        end
    end

    // ==================================================
    // Checks and bus tasks
    // ==================================================

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_csr(input string name, input csr_data_t got, input csr_data_t exp);
        if (got !== exp)
        begin
            $display("error %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic check_count(input string name, input csr_data_t got, input csr_data_t exp);
        if (got !== exp)
        begin
            $display("error %s: got %h, expected %h", name, got, exp);
            fail_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic write_csr(input int grp, input int idx, input csr_data_t data);
        mmio_write = 1'b1;
        mmio_address = MMIO_ADDR_WIDTH'((grp << CSR_IDX_BITS) + idx);
        mmio_writedata = data;
        next_cycle();
        mmio_write = 1'b0;
    endtask

    // The response is due exactly one cycle after the read is sampled
    // and is gone again in the cycle after that
    task automatic read_csr(input int grp, input int idx, output csr_data_t data);
        mmio_read = 1'b1;
        mmio_address = MMIO_ADDR_WIDTH'((grp << CSR_IDX_BITS) + idx);
        next_cycle();
        mmio_read = 1'b0;
        check_count("mmio_readdatavalid", csr_data_t'(mmio_readdatavalid), 64'd1);
        data = mmio_readdata;
        next_cycle();
        check_count("mmio_readdatavalid", csr_data_t'(mmio_readdatavalid), 64'd0);
    endtask

    task automatic wait_done(input int eng);
        csr_data_t status;
        int        polls;
        status = '0;
        polls = 0;
        while (status[1] == 1'b0)
        begin
            if (polls == POLL_LIMIT)
            begin
                $display("engine %0d did not report done within %0d polls", eng, POLL_LIMIT);
                fail_run();
            end
            read_csr(eng + 1, 0, status);
            polls++;
        end
        check_count("status", status, 64'h2);
    endtask

    task automatic start_run(input int run);
        int          eng;
        mem_addr_t   base;
        mem_addr_t   count;
        logic [31:0] seed;
        mem_addr_t   offset;
        eng = int'(vec[run * VEC_FIELDS]);
        base = vec[run * VEC_FIELDS + 1][15:0];
        count = vec[run * VEC_FIELDS + 2][15:0];
        seed = vec[run * VEC_FIELDS + 3][31:0];
        offset = vec[run * VEC_FIELDS + 4][15:0];
        corrupt_en[eng] = (offset != 16'hFFFF);
        corrupt_addr[eng] = base + offset;
        write_csr(eng + 1, 0, csr_data_t'(base));
        write_csr(eng + 1, 1, {seed, 16'h0000, count});
        write_csr(eng + 1, 2, '0);
    endtask

    task automatic verify_results(input int run);
        int        eng;
        csr_data_t value;
        eng = int'(vec[run * VEC_FIELDS]);
        wait_done(eng);
        read_csr(eng + 1, 1, value);
        check_csr("checksum", value, vec[run * VEC_FIELDS + 5]);
        read_csr(eng + 1, 2, value);
        check_count("mismatch_count", value, vec[run * VEC_FIELDS + 6]);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        csr_data_t value;
        $readmemh("tb/afu_vectors.txt", vec);
        arst_n = 1'b0;
        mmio_write = 1'b0;
        mmio_read = 1'b0;
        mmio_address = '0;
        mmio_writedata = '0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Engines stay off the memory bus until started
        for (int c = 0; c < 8; c++)
        begin
            next_cycle();
            check_count("mem_write", csr_data_t'(mem_write), '0);
            check_count("mem_read", csr_data_t'(mem_read), '0);
            check_count("mmio_readdatavalid", csr_data_t'(mmio_readdatavalid), '0);
        end
        for (int e = 0; e < NUM_ENGINES; e++)
        begin
            read_csr(e + 1, 0, value);
            check_count("status", value, '0);
            read_csr(e + 1, 3, value);
            check_csr("engine_number", value, csr_data_t'(e));
        end

        // Global group and then a group past the last engine
        read_csr(0, 0, value);
        check_csr("test_id_low", value, TEST_ID[63:0]);
        read_csr(0, 1, value);
        check_csr("test_id_high", value, TEST_ID[127:64]);
        read_csr(0, 2, value);
        check_csr("num_engines", value, csr_data_t'(NUM_ENGINES));
        read_csr(0, 3, value);
        check_csr("global_reserved", value, '0);
        read_csr(NUM_ENGINES + 1, 1, value);
        check_csr("unmapped_group", value, '0);
        check_count("mem_write", csr_data_t'(mem_write), '0);
        check_count("mem_read", csr_data_t'(mem_read), '0);

        // Clean run and corrupted run without stalls
        start_run(0);
        verify_results(0);
        start_run(1);
        verify_results(1);

        // Both engines together under random stalls
        stall_en = 1'b1;
        start_run(2);
        start_run(3);
        verify_results(2);
        verify_results(3);

        // A second configuration and start while active must be dropped
        start_run(4);
        read_csr(2, 0, value);
        check_count("status", value, 64'h1);
        write_csr(2, 0, csr_data_t'(16'h0100));
        write_csr(2, 1, {32'h1234ABCD, 16'h0000, 16'h0020});
        write_csr(2, 2, '0);
        verify_results(4);

        // Zero length run finishes at once with empty results
        start_run(5);
        verify_results(5);

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== tb/afu_vectors.txt ====
// engine base count seed corrupt_offset(FFFF none) checksum mismatch_count
// Runs 0 and 1 alone, 2 and 3 together, 4 with a second start, 5 empty
0 0100 0020 1234ABCD FFFF 469579A0000021F0 0
0 0100 0020 1234ABCD 0005 469579A0000021EF 1
0 FFF8 0010 DEADBEEF FFFF EADBEEF00007FFF8 0
1 2000 0030 00000001 0002 0000003000060469 1
1 0040 0040 0F0F0F0F FFFF C3C3C3C0000017E0 0
0 0000 0000 00000055 FFFF 0000000000000000 0

// ==== vlog.f ====
src/afu_pkg.sv
src/engine_csr_if.sv
src/csr_mgr.sv
src/local_mem_engine.sv
src/afu_top.sv
tb/afu_assertions.sv
tb/tb_afu.sv

// ==== Makefile ====
TOP = tb_afu

.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/100ps --top-module $(TOP) -f vlog.f
	@out=$$(./obj_dir/V$(TOP) 2>&1); echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
